// File: dcache_pkg.sv
package dcache_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Cache geometry
	////////////////////////////////////////////////////////////////////////////

	// Eight sets of two ways, two words per block
	localparam int N_SETS = 8;
	localparam int IDX_W  = 3;
	localparam int TAG_W  = 26;
	localparam int N_WAYS = 2;

	// One data or address word
	typedef logic [31:0] word_t;

	// Memory location that receives the hit count at the end of a flush
	localparam word_t COUNT_ADDR = 32'h0000_3100;

	// Address word, seen either raw or split into its cache fields
	// 26 bit tag | 3 bit index | 1 bit block offset | 2 bit byte offset
	typedef union packed {
		word_t raw;
		struct packed {
			logic [TAG_W-1:0] tag;
			logic [IDX_W-1:0] idx;
			logic             blkoff;
			logic [1:0]       byteoff;
		} f;
	} dcache_addr_t;

	////////////////////////////////////////////////////////////////////////////
	// Controller states
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		IDLE    = 4'b0001,
		WB1     = 4'b0010,  // victim writeback, word 0
		WB2     = 4'b0011,  // victim writeback, word 1
		FD1     = 4'b0100,  // fetch, word 0
		FD2     = 4'b0101,  // fetch, word 1
		WBD1    = 4'b0110,  // flush writeback, word 0
		WBD2    = 4'b0111,  // flush writeback, word 1
		DCHK    = 4'b1000,  // look for the next dirty block
		WRCNT   = 4'b1010,  // write the hit count
		FLUSHED = 4'b1011
	} state_t;

endpackage

// File: dcache_array.sv
`timescale 1ns/100ps

module dcache_array (
	input  logic                     CLK,
	input  logic                     nRST,
	input  dcache_pkg::dcache_addr_t addr,
	input  logic                     rd_req,
	input  logic                     wr_req,
	input  dcache_pkg::word_t        store_data,
	input  logic                     fill_en,
	input  logic                     fill_word,
	input  dcache_pkg::word_t        fill_data,
	input  logic                     flush_wb,
	input  logic                     wb_done,
	input  logic                     wb_word,
	output logic                     hit,
	output dcache_pkg::word_t        load_data,
	output logic                     victim_dirty,
	output logic                     some_dirty,
	output logic [dcache_pkg::TAG_W-1:0] wb_tag,
	output logic [dcache_pkg::IDX_W-1:0] wb_idx,
	output dcache_pkg::word_t        wb_data
);

	// Block state, indexed [way][set]
	logic                         valid [dcache_pkg::N_WAYS][dcache_pkg::N_SETS];
	logic                         dirty [dcache_pkg::N_WAYS][dcache_pkg::N_SETS];
	logic [dcache_pkg::TAG_W-1:0] tags  [dcache_pkg::N_WAYS][dcache_pkg::N_SETS];
	dcache_pkg::word_t            data  [dcache_pkg::N_WAYS][dcache_pkg::N_SETS][2];

	// One bit per set, names the way to replace next
	logic [dcache_pkg::N_SETS-1:0] lru;

	logic [dcache_pkg::IDX_W-1:0]  idx;
	logic [dcache_pkg::N_WAYS-1:0] way_hit;
	logic                          hit_way;
	logic                          vict_way;
	logic                          rd_hit;
	logic                          wr_hit;

	// Flush scan result and the selected writeback source
	logic                          scan_way;
	logic [dcache_pkg::IDX_W-1:0]  scan_idx;
	logic                          src_way;
	logic [dcache_pkg::IDX_W-1:0]  src_idx;

	assign idx      = addr.f.idx;
	assign vict_way = lru[idx];

	////////////////////////////////////////////////////////////////////////////
	// Lookup
	////////////////////////////////////////////////////////////////////////////

	// Tag compare against both ways of the indexed set
	always_comb begin
		for (int w = 0; w < dcache_pkg::N_WAYS; w++) begin
			way_hit[w] = valid[w][idx] && (tags[w][idx] == addr.f.tag);
		end
	end

	// Way 0 wins if both ever matched
	assign hit_way   = !way_hit[0];
	assign hit       = (rd_req || wr_req) && (|way_hit);
	assign rd_hit    = rd_req && hit;
	assign wr_hit    = wr_req && hit;

	// Word picked by block offset, meaningful only with hit
	assign load_data = data[hit_way][idx][addr.f.blkoff];

	////////////////////////////////////////////////////////////////////////////
	// Writeback source
	////////////////////////////////////////////////////////////////////////////

	// Priority scan, walked downward so the lowest set and way is left
	always_comb begin
		scan_way   = 1'b0;
		scan_idx   = '0;
		some_dirty = 1'b0;
		for (int s = dcache_pkg::N_SETS - 1; s >= 0; s--) begin
			for (int w = dcache_pkg::N_WAYS - 1; w >= 0; w--) begin
				if (dirty[w][s]) begin
					scan_way   = 1'(w);
					scan_idx   = dcache_pkg::IDX_W'(s);
					some_dirty = 1'b1;
				end
			end
		end
	end

	// Flush takes the scan, a miss takes the LRU way of its own set
	assign src_way      = flush_wb ? scan_way : vict_way;
	assign src_idx      = flush_wb ? scan_idx : idx;
	assign wb_tag       = tags[src_way][src_idx];
	assign wb_idx       = src_idx;
	assign wb_data      = data[src_way][src_idx][wb_word];
	assign victim_dirty = dirty[vict_way][idx];

	////////////////////////////////////////////////////////////////////////////
	// Control bits
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lru <= '0;
			for (int s = 0; s < dcache_pkg::N_SETS; s++) begin
				for (int w = 0; w < dcache_pkg::N_WAYS; w++) begin
					valid[w][s] <= 1'b0;
					dirty[w][s] <= 1'b0;
				end
			end
		end else begin
			// Any hit makes the other way the next victim
			if (rd_hit || wr_hit) begin
				lru[idx] <= !hit_way;
			end
			if (wr_hit) begin
				dirty[hit_way][idx] <= 1'b1;
			end
			// Block turns valid only once its second word is in
			if (fill_en) begin
				valid[vict_way][idx] <= fill_word;
				dirty[vict_way][idx] <= 1'b0;
			end
			// Second word written back, block is clean again
			if (wb_done) begin
				dirty[src_way][src_idx] <= 1'b0;
			end
		end
	end

	// Tag and data storage
	always_ff @(posedge CLK) begin
		if (wr_hit) begin
			data[hit_way][idx][addr.f.blkoff] <= store_data;
		end
		if (fill_en) begin
			tags[vict_way][idx]            <= addr.f.tag;
			data[vict_way][idx][fill_word] <= fill_data;
		end
	end

endmodule

// File: dcache_fsm.sv
`timescale 1ns/100ps

module dcache_fsm (
	input  logic CLK,
	input  logic nRST,
	input  logic req,
	input  logic hit,
	input  logic halt,
	input  logic victim_dirty,
	input  logic some_dirty,
	input  logic mem_wait,
	output logic mem_ren,
	output logic mem_wen,
	output logic fill_en,
	output logic fill_word,
	output logic wb_done,
	output logic flush_wb,
	output logic cnt_sel,
	output logic miss_start,
	output logic flushed
);

	dcache_pkg::state_t state;
	dcache_pkg::state_t next_state;

	// Memory side finished the current word
	logic xfer_ok;

	assign xfer_ok = !mem_wait;

	////////////////////////////////////////////////////////////////////////////
	// State register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= dcache_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		// Hold by default, covers every wait on memory
		next_state = state;
		case (state)
			dcache_pkg::IDLE: begin
				// Miss takes priority over halt
				if (req && !hit) begin
					next_state = victim_dirty ? dcache_pkg::WB1 : dcache_pkg::FD1;
				end else if (halt && !req) begin
					next_state = dcache_pkg::DCHK;
				end
			end
			dcache_pkg::WB1: begin
				if (xfer_ok) next_state = dcache_pkg::WB2;
			end
			dcache_pkg::WB2: begin
				if (xfer_ok) next_state = dcache_pkg::FD1;
			end
			dcache_pkg::FD1: begin
				if (xfer_ok) next_state = dcache_pkg::FD2;
			end
			dcache_pkg::FD2: begin
				// Request hits on return to IDLE
				if (xfer_ok) next_state = dcache_pkg::IDLE;
			end
			dcache_pkg::DCHK: begin
				// Loop until the scan finds nothing dirty
				next_state = some_dirty ? dcache_pkg::WBD1 : dcache_pkg::WRCNT;
			end
			dcache_pkg::WBD1: begin
				if (xfer_ok) next_state = dcache_pkg::WBD2;
			end
			dcache_pkg::WBD2: begin
				if (xfer_ok) next_state = dcache_pkg::DCHK;
			end
			dcache_pkg::WRCNT: begin
				if (xfer_ok) next_state = dcache_pkg::FLUSHED;
			end
			// FLUSHED has no way out until reset
			default: begin
				next_state = state;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////////////////////

	// State decoded outputs
	always_comb begin
		mem_ren   = 1'b0;
		mem_wen   = 1'b0;
		fill_word = 1'b0;
		flush_wb  = 1'b0;
		cnt_sel   = 1'b0;
		flushed   = 1'b0;
		case (state)
			dcache_pkg::WB1: begin
				mem_wen = 1'b1;
			end
			dcache_pkg::WB2: begin
				mem_wen   = 1'b1;
				fill_word = 1'b1;
			end
			dcache_pkg::FD1: begin
				mem_ren = 1'b1;
			end
			dcache_pkg::FD2: begin
				mem_ren   = 1'b1;
				fill_word = 1'b1;
			end
			dcache_pkg::WBD1: begin
				mem_wen  = 1'b1;
				flush_wb = 1'b1;
			end
			dcache_pkg::WBD2: begin
				mem_wen   = 1'b1;
				flush_wb  = 1'b1;
				fill_word = 1'b1;
			end
			dcache_pkg::WRCNT: begin
				mem_wen = 1'b1;
				cnt_sel = 1'b1;
			end
			dcache_pkg::FLUSHED: begin
				flushed = 1'b1;
			end
			default: begin
				mem_ren = 1'b0;
			end
		endcase
	end

	// Word strobes, only in the cycle the memory completes
	assign fill_en = ((state == dcache_pkg::FD1) || (state == dcache_pkg::FD2)) && xfer_ok;
	assign wb_done = ((state == dcache_pkg::WB2) || (state == dcache_pkg::WBD2)) && xfer_ok;

	// One pulse per miss, the cycle IDLE is left
	assign miss_start = (state == dcache_pkg::IDLE) && req && !hit;

endmodule

// File: dcache_hit_counter.sv
`timescale 1ns/100ps

module dcache_hit_counter (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              hit_done,
	input  logic              miss_start,
	output dcache_pkg::word_t hit_count
);

	// Every request ends in exactly one hit cycle
	dcache_pkg::word_t hits;

	// Requests that had to be fetched first
	dcache_pkg::word_t misses;

	////////////////////////////////////////////////////////////////////////////
	// Counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			hits <= '0;
		end else if (hit_done) begin
			hits <= hits + 1'b1;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			misses <= '0;
		end else if (miss_start) begin
			misses <= misses + 1'b1;
		end
	end

	// A missed request also hits after its fetch
	// Subtracting leaves hits on first access
	assign hit_count = hits - misses;

endmodule

// File: dcache.sv
`timescale 1ns/100ps

module dcache (
	input  logic              CLK,
	input  logic              nRST,
	// Datapath side
	input  logic              halt,
	input  logic              dmem_ren,
	input  logic              dmem_wen,
	input  dcache_pkg::word_t dmem_addr,
	input  dcache_pkg::word_t dmem_store,
	output logic              dhit,
	output dcache_pkg::word_t dmem_load,
	output logic              flushed,
	// Memory side
	output logic              mem_ren,
	output logic              mem_wen,
	output dcache_pkg::word_t mem_addr,
	output dcache_pkg::word_t mem_store,
	input  logic              mem_wait,
	input  dcache_pkg::word_t mem_load
);

	dcache_pkg::dcache_addr_t req_addr;
	dcache_pkg::dcache_addr_t mem_a;

	logic                         req;
	logic                         fill_en;
	logic                         fill_word;
	logic                         victim_dirty;
	logic                         some_dirty;
	logic                         wb_done;
	logic                         flush_wb;
	logic                         cnt_sel;
	logic                         miss_start;
	logic [dcache_pkg::TAG_W-1:0] wb_tag;
	logic [dcache_pkg::IDX_W-1:0] wb_idx;
	dcache_pkg::word_t            wb_data;
	dcache_pkg::word_t            hit_count;

	assign req_addr = dcache_pkg::dcache_addr_t'(dmem_addr);
	assign req      = dmem_ren || dmem_wen;

	dcache_array u_array (
		.CLK          (CLK),
		.nRST         (nRST),
		.addr         (req_addr),
		.rd_req       (dmem_ren),
		.wr_req       (dmem_wen),
		.store_data   (dmem_store),
		.fill_en      (fill_en),
		.fill_word    (fill_word),
		.fill_data    (mem_load),
		.flush_wb     (flush_wb),
		.wb_done      (wb_done),
		.wb_word      (fill_word),
		.hit          (dhit),
		.load_data    (dmem_load),
		.victim_dirty (victim_dirty),
		.some_dirty   (some_dirty),
		.wb_tag       (wb_tag),
		.wb_idx       (wb_idx),
		.wb_data      (wb_data)
	);

	dcache_fsm u_fsm (
		.CLK          (CLK),
		.nRST         (nRST),
		.req          (req),
		.hit          (dhit),
		.halt         (halt),
		.victim_dirty (victim_dirty),
		.some_dirty   (some_dirty),
		.mem_wait     (mem_wait),
		.mem_ren      (mem_ren),
		.mem_wen      (mem_wen),
		.fill_en      (fill_en),
		.fill_word    (fill_word),
		.wb_done      (wb_done),
		.flush_wb     (flush_wb),
		.cnt_sel      (cnt_sel),
		.miss_start   (miss_start),
		.flushed      (flushed)
	);

	dcache_hit_counter u_counter (
		.CLK        (CLK),
		.nRST       (nRST),
		.hit_done   (dhit),
		.miss_start (miss_start),
		.hit_count  (hit_count)
	);

	////////////////////////////////////////////////////////////////////////////
	// Memory address and store data
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		mem_a = req_addr;
		if (cnt_sel) begin
			mem_a.raw = dcache_pkg::COUNT_ADDR;
		end else if (mem_ren) begin
			// Fetch keeps the request tag and index
			mem_a.f.blkoff  = fill_word;
			mem_a.f.byteoff = 2'b00;
		end else begin
			// Writeback goes to the victim's own address
			mem_a.f.tag     = wb_tag;
			mem_a.f.idx     = wb_idx;
			mem_a.f.blkoff  = fill_word;
			mem_a.f.byteoff = 2'b00;
		end
	end

	assign mem_addr  = mem_a.raw;
	assign mem_store = cnt_sel ? hit_count : wb_data;

endmodule

// File: dcache_checker.sv
`timescale 1ns/100ps

module dcache_checker (
	input logic              CLK,
	input logic              nRST,
	input logic              mem_ren,
	input logic              mem_wen,
	input logic              mem_wait,
	input dcache_pkg::word_t mem_addr,
	input dcache_pkg::word_t mem_store,
	input logic              flushed
);

	// Number of failed assertions so far
	int fails = 0;

	// Read and write strobes are exclusive
	a_ren_wen_excl: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_ren && mem_wen))
		else begin
			fails = fails + 1;
			$error("mem_ren and mem_wen high together");
		end

	// Request held steady while memory stalls
	a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
		(mem_ren || mem_wen) && mem_wait |=>
		$stable(mem_addr) && $stable(mem_store) && (mem_ren || mem_wen))
		else begin
			fails = fails + 1;
			$error("memory request changed during mem_wait");
		end

	// Sticky until reset
	a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
		flushed |=> flushed)
		else begin
			fails = fails + 1;
			$error("flushed fell before reset");
		end

endmodule

// File: dcache_monitor.sv
`timescale 1ns/100ps

module dcache_monitor (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              mem_ren,
	input  logic              mem_wen,
	input  logic              mem_wait,
	input  dcache_pkg::word_t mem_addr,
	input  dcache_pkg::word_t mem_store,
	input  logic              flushed
);

	int                errors;
	int                checks;
	int                tests;
	int                failed_tests;
	// Completed memory transfers since reset
	int                xfers;
	int                test_err_mark;
	logic              seen_flushed;
	dcache_pkg::word_t last_addr;
	dcache_pkg::word_t last_data;

	initial begin
		errors        = 0;
		checks        = 0;
		tests         = 0;
		failed_tests  = 0;
		xfers         = 0;
		test_err_mark = 0;
		seen_flushed  = 1'b0;
		last_addr     = '0;
		last_data     = '0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Port watcher
	////////////////////////////////////////////////////////////////////////////

	// A transfer completes on the edge that ends a cycle with mem_wait low
	always @(posedge CLK) begin
		if (nRST) begin
			if ((mem_ren || mem_wen) && !mem_wait) begin
				xfers = xfers + 1;
				if (mem_wen) begin
					last_addr = mem_addr;
					last_data = mem_store;
				end
			end
			if (seen_flushed && !flushed) begin
				note_failure("flushed fell after it was set");
			end
			if (flushed) begin
				seen_flushed = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare and report
	////////////////////////////////////////////////////////////////////////////

	task automatic note_failure(input string what);
		errors = errors + 1;
		$display("Error: %s", what);
	endtask

	task automatic compare_word(input string name, input dcache_pkg::word_t exp,
			input dcache_pkg::word_t got);
		checks = checks + 1;
		if (exp !== got) begin
			errors = errors + 1;
			$display("Mismatch %s exp %h got %h", name, exp, got);
		end
	endtask

	task automatic start_test();
		test_err_mark = errors;
	endtask

	task automatic end_test(input int num, input string desc);
		tests = tests + 1;
		if (errors != test_err_mark) begin
			failed_tests = failed_tests + 1;
			$display("test %0d %s: FAILED", num, desc);
		end else begin
			$display("test %0d %s: ok", num, desc);
		end
	endtask

	// Count write must be the last memory write before flushed rose
	task automatic compare_flush(input dcache_pkg::word_t exp_count);
		compare_word("mem_addr", dcache_pkg::COUNT_ADDR, last_addr);
		compare_word("mem_store", exp_count, last_data);
	endtask

	task automatic print_counts();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
	endtask

endmodule

// File: dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;

	localparam int TIMEOUT   = 400;
	localparam int STIM_MAX  = 256;

	logic              CLK;
	logic              nRST;
	logic              halt;
	logic              dmem_ren;
	logic              dmem_wen;
	dcache_pkg::word_t dmem_addr;
	dcache_pkg::word_t dmem_store;
	logic              dhit;
	dcache_pkg::word_t dmem_load;
	logic              flushed;
	logic              mem_ren;
	logic              mem_wen;
	dcache_pkg::word_t mem_addr;
	dcache_pkg::word_t mem_store;
	logic              mem_wait;
	dcache_pkg::word_t mem_load;

	// Four words per stim line: op, address, data, expected
	dcache_pkg::word_t stim [STIM_MAX*4];

	// Memory model, words not yet written follow the fill rule
	dcache_pkg::word_t mem [dcache_pkg::word_t];
	int                wait_left;
	logic              timed_out;

	dcache dcache_i (.*);

	dcache_monitor mon (
		.CLK       (CLK),
		.nRST      (nRST),
		.mem_ren   (mem_ren),
		.mem_wen   (mem_wen),
		.mem_wait  (mem_wait),
		.mem_addr  (mem_addr),
		.mem_store (mem_store),
		.flushed   (flushed)
	);

	bind dcache dcache_checker dcache_checker_i (
		.CLK       (CLK),
		.nRST      (nRST),
		.mem_ren   (mem_ren),
		.mem_wen   (mem_wen),
		.mem_wait  (mem_wait),
		.mem_addr  (mem_addr),
		.mem_store (mem_store),
		.flushed   (flushed)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory model
	////////////////////////////////////////////////////////////////////////////

	function automatic dcache_pkg::word_t mem_word(input dcache_pkg::word_t a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return a ^ 32'hA5A5_A5A5;
	endfunction

	// New random wait length after every completed transfer and while idle
	always @(posedge CLK) begin
		if (!(mem_ren || mem_wen) || !mem_wait) begin
			if (mem_wen && !mem_wait) begin
				mem[mem_addr] = mem_store;
			end
			wait_left = $urandom % 4;
			mem_wait <= (wait_left != 0);
		end else begin
			wait_left = wait_left - 1;
			mem_wait <= (wait_left != 0);
		end
	end

	// Address settles after the edge, read data is ready well before the next
	always @(negedge CLK) begin
		mem_load <= mem_word(mem_addr);
	end

	////////////////////////////////////////////////////////////////////////////
	// Datapath side
	////////////////////////////////////////////////////////////////////////////

	// Hold the request until dhit is seen, then drop it on the next edge
	task automatic do_request(input logic wr, input dcache_pkg::word_t a,
			input dcache_pkg::word_t d, output dcache_pkg::word_t load);
		int n;
		n = 0;
		@(posedge CLK);
		dmem_ren   <= !wr;
		dmem_wen   <= wr;
		dmem_addr  <= a;
		dmem_store <= d;
		@(negedge CLK);
		while (!dhit && n < TIMEOUT) begin
			@(negedge CLK);
			n++;
		end
		if (!dhit) begin
			timed_out = 1'b1;
			mon.note_failure($sformatf("no dhit for address %h", a));
		end
		load = dmem_load;
		@(posedge CLK);
		dmem_ren <= 1'b0;
		dmem_wen <= 1'b0;
	endtask

	task automatic do_halt(input dcache_pkg::word_t exp_count);
		int n;
		n = 0;
		@(posedge CLK);
		halt <= 1'b1;
		@(negedge CLK);
		while (!flushed && n < TIMEOUT) begin
			@(negedge CLK);
			n++;
		end
		if (!flushed) begin
			timed_out = 1'b1;
			mon.note_failure("flushed never rose after halt");
		end else begin
			mon.compare_flush(exp_count);
			// Still set a few cycles on
			repeat (3) @(negedge CLK);
			mon.compare_word("flushed", 32'h1, {31'b0, flushed});
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		dcache_pkg::word_t op;
		dcache_pkg::word_t a;
		dcache_pkg::word_t d;
		dcache_pkg::word_t exp;
		dcache_pkg::word_t got;
		int                mark;
		int                line;
		void'($urandom(87250));
		nRST       = 1'b0;
		halt       = 1'b0;
		dmem_ren   = 1'b0;
		dmem_wen   = 1'b0;
		dmem_addr  = '0;
		dmem_store = '0;
		mem_wait   = 1'b0;
		mem_load   = '0;
		wait_left  = 0;
		timed_out  = 1'b0;
		for (int i = 0; i < STIM_MAX*4; i++) begin
			stim[i] = '0;
		end
		$readmemh("dcache_stim.txt", stim);
		repeat (5) @(posedge CLK);
		nRST <= 1'b1;

		// Idle outputs straight after reset
		@(negedge CLK);
		mon.start_test();
		mon.compare_word("mem_ren", 32'h0, {31'b0, mem_ren});
		mon.compare_word("mem_wen", 32'h0, {31'b0, mem_wen});
		mon.compare_word("flushed", 32'h0, {31'b0, flushed});
		mon.compare_word("dhit", 32'h0, {31'b0, dhit});
		mon.end_test(0, "reset");

		line = 0;
		op   = stim[0];
		while (op != 0 && line < STIM_MAX && !timed_out) begin
			a   = stim[line*4 + 1];
			d   = stim[line*4 + 2];
			exp = stim[line*4 + 3];
			mon.start_test();
			case (op)
				1: begin
					// Data column holds the expected number of transfers
					mark = mon.xfers;
					do_request(1'b0, a, '0, got);
					mon.compare_word("dmem_load", exp, got);
					mon.compare_word("transfers", d, mon.xfers - mark);
					mon.end_test(line + 1, $sformatf("read %h", a));
				end
				2: begin
					do_request(1'b1, a, d, got);
					mon.end_test(line + 1, $sformatf("write %h", a));
				end
				3: begin
					do_halt(exp);
					mon.end_test(line + 1, "halt and flush");
				end
				4: begin
					mon.compare_word($sformatf("mem[%h]", a), exp, mem_word(a));
					mon.end_test(line + 1, $sformatf("memory %h", a));
				end
				default: begin
					mon.note_failure($sformatf("unknown op %h in stim", op));
					mon.end_test(line + 1, "bad op");
				end
			endcase
			line++;
			op = stim[line*4];
		end

		mon.print_counts();
		if (mon.errors == 0 && !timed_out && dcache_i.dcache_checker_i.fails == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: dcache_stim.txt
// op addr data exp, op 1 read (data = memory transfers), 2 write, 3 halt (exp = hit count)
// op 4 memory check after flush, op 0 ends the list
1 00000108 00000002 a5a5a4ad
2 00000108 11112222 00000000
1 00000108 00000000 11112222
1 00000208 00000002 a5a5a7ad
1 00000308 00000004 a5a5a6ad
2 0000030c deadbeef 00000000
2 00000014 0badf00d 00000000
1 00000014 00000000 0badf00d
3 00000000 00000000 00000004
4 00000108 00000000 11112222
4 0000010c 00000000 a5a5a4a9
4 0000030c 00000000 deadbeef
4 00000308 00000000 a5a5a6ad
4 00000014 00000000 0badf00d
4 00000010 00000000 a5a5a5b5
0 00000000 00000000 00000000

// File: tb.f
dcache_pkg.sv
dcache_array.sv
dcache_fsm.sv
dcache_hit_counter.sv
dcache.sv
dcache_checker.sv
dcache_monitor.sv
dcache_tb.sv
